// ==== hw/rom_addr_router.sv ====
/*
 * ROM address router
 * Sorts each downloaded byte into a region, rebases its address to the
 * region start plus offset, sets bank and byte mask, and descrambles
 * CPU bytes when the header flags ask for it. Purely combinational.
 */
`default_nettype none

module rom_addr_router #(
    parameter int          REGSIZE    = 24,
    parameter int          CFG_BYTE   = 39,
    parameter logic [21:0] CPU_OFFSET = 22'h0,
    parameter logic [21:0] SND_OFFSET = 22'h0,
    parameter logic [21:0] PCM_OFFSET = 22'h0,
    parameter logic [21:0] GFX_OFFSET = 22'h0
) (
    input  wire  [rom_load_pkg::DL_ADDR_W-1:0]   ioctl_addr,
    input  wire  [7:0]                           ioctl_data,
    input  rom_load_pkg::start_table_t           starts,
    input  wire                                  decrypt,
    input  wire                                  scramble_bit,
    output rom_load_pkg::route_t                 route
);

    import rom_load_pkg::*;

    localparam int CFG_END = (REGSIZE + 16 > CFG_BYTE) ? REGSIZE + 16 : CFG_BYTE + 1;

    logic [DL_ADDR_W-1:0] bulk;
    logic [15:0]          kb;
    logic [DL_ADDR_W-1:0] snd_rel;
    logic [DL_ADDR_W-1:0] pcm_rel;
    logic [DL_ADDR_W-1:0] gfx_rel;
    rom_region_e          region;
    logic                 scramble;
    logic [7:0]           data_out;

    function automatic logic [7:0] descramble(input logic [7:0] d);
        logic [7:0] r;
        r = 8'h00;
        if (d[0])  r = r ^ 8'h04;
        if (d[1])  r = r ^ 8'h21;
        if (d[2])  r = r ^ 8'h01;
        if (!d[3]) r = r ^ 8'h50;   // clear bit contributes
        if (d[4])  r = r ^ 8'h40;
        if (d[5])  r = r ^ 8'h06;
        if (d[6])  r = r ^ 8'h08;
        if (!d[7]) r = r ^ 8'h88;   // clear bit contributes
        return r;
    endfunction

    assign bulk    = ioctl_addr - HEADER_BYTES;             // header excluded
    assign kb      = {1'b0, bulk[24:10]};
    assign snd_rel = bulk - {starts.snd_start[14:0], 10'd0};
    assign pcm_rel = bulk - {starts.pcm_start[14:0], 10'd0};
    assign gfx_rel = bulk - {starts.gfx_start[14:0], 10'd0};

    always_comb begin
        if (ioctl_addr < START_BYTES)                region = RGN_START;
        else if (ioctl_addr < DL_ADDR_W'(CFG_END))   region = RGN_CFG;
        else if (ioctl_addr < HEADER_BYTES)          region = RGN_NONE;
        else if (kb < starts.snd_start)              region = RGN_CPU;
        else if (kb < starts.pcm_start)              region = RGN_SND;
        else if (kb < starts.gfx_start)              region = RGN_PCM;
        else if (kb < starts.qsnd_start)             region = RGN_GFX;
        else                                         region = RGN_QSND;
    end

    // odd/even parity against the flag picks which CPU bytes are scrambled
    assign scramble = region == RGN_CPU && decrypt && bulk[19] && (bulk[0] ^ scramble_bit);
    assign data_out = scramble ? descramble(ioctl_data) : ioctl_data;

    always_comb begin
        route.region   = region;
        route.raw      = ioctl_data;
        route.req.data = {2{data_out}};
        route.req.mask = ioctl_addr[0] ? 2'b01 : 2'b10;
        route.req.bank = 2'd1;
        case (region)
            RGN_CPU: begin
                route.req.addr = bulk[22:1] + CPU_OFFSET;
                route.req.bank = 2'd3;
            end
            RGN_SND: route.req.addr = snd_rel[22:1] + SND_OFFSET;
            RGN_PCM: route.req.addr = pcm_rel[22:1] + PCM_OFFSET;
            RGN_GFX: begin
                route.req.addr = gfx_rel[22:1] + GFX_OFFSET;
                route.req.bank = 2'd2;
            end
            default: route.req.addr = {9'd0, bulk[12:0]};  // internal ROM index
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/rom_header_regs.sv ====
/*
 * ROM header registers
 * Collects the four 16-bit section starts from the first header bytes and
 * latches the descramble flags found in the configuration byte.
 */
`default_nettype none

module rom_header_regs #(
    parameter int REGSIZE  = 24,
    parameter int CFG_BYTE = 39
) (
    input  wire                                  clk,
    input  wire                                  rst_n,
    input  wire  [rom_load_pkg::DL_ADDR_W-1:0]   ioctl_addr,
    input  wire  [7:0]                           ioctl_data,
    input  wire                                  ioctl_wr,
    input  wire                                  downloading,
    output rom_load_pkg::start_table_t           starts,
    output logic                                 decrypt,
    output logic                                 scramble_bit
);

    import rom_load_pkg::*;

    // the flag byte always counts as configuration
    localparam int CFG_END = (REGSIZE + 16 > CFG_BYTE) ? REGSIZE + 16 : CFG_BYTE + 1;

    logic in_start;
    logic in_cfg;
    logic at_flags;

    assign in_start = ioctl_addr < START_BYTES;
    assign in_cfg   = ioctl_addr >= CFG_FIRST && ioctl_addr < DL_ADDR_W'(CFG_END);
    assign at_flags = in_cfg && ioctl_addr == DL_ADDR_W'(CFG_BYTE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            starts       <= '0;
            decrypt      <= 1'b0;
            scramble_bit <= 1'b0;
        end else begin
            if (!downloading) begin
                decrypt <= 1'b0;                    // drops between downloads
            end else if (ioctl_wr) begin
                if (in_start) begin
                    // new byte enters at the top, first byte ends lowest
                    starts <= start_table_t'({ioctl_data, starts[63:8]});
                end
                if (at_flags) begin
                    decrypt      <= ioctl_data[7];
                    scramble_bit <= ioctl_data[6];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/rom_load_pkg.sv ====
/*
 * ROM download package
 * Region and writer-state enums, the SDRAM write request, the routed
 * byte and the start table, plus the layout of the 64-byte file header.
 */
`default_nettype none

package rom_load_pkg;

    parameter int DL_ADDR_W = 25;                            // loader address width

    localparam logic [DL_ADDR_W-1:0] HEADER_BYTES = 25'd64;  // whole header
    localparam logic [DL_ADDR_W-1:0] START_BYTES  = 25'd8;   // start table part
    localparam logic [DL_ADDR_W-1:0] CFG_FIRST    = 25'd8;   // first config byte

    typedef enum logic [2:0] {
        RGN_START,
        RGN_CFG,
        RGN_CPU,
        RGN_SND,
        RGN_PCM,
        RGN_GFX,
        RGN_QSND,
        RGN_NONE
    } rom_region_e;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_LOAD,
        WR_CLEAR
    } wr_state_e;

    // fields listed MSB first, so snd_start holds the first two header bytes
    typedef struct packed {
        logic [15:0] qsnd_start;
        logic [15:0] gfx_start;
        logic [15:0] pcm_start;
        logic [15:0] snd_start;
    } start_table_t;

    typedef struct packed {
        logic [21:0] addr;  // word address
        logic [15:0] data;  // byte in both halves
        logic [1:0]  mask;  // active low
        logic [1:0]  bank;
    } prog_req_t;

    typedef struct packed {
        rom_region_e region;
        prog_req_t   req;
        logic [7:0]  raw;   // byte as received
    } route_t;

endpackage

`default_nettype wire

// ==== hw/rom_loader_top.sv ====
/*
 * ROM loader top level
 * Header registers, address router and SDRAM writer for the arcade
 * ROM download path.
 */
`default_nettype none

module rom_loader_top #(
    parameter int          REGSIZE     = 24,
    parameter int          CFG_BYTE    = 39,
    parameter logic [21:0] CPU_OFFSET  = 22'h0,
    parameter logic [21:0] SND_OFFSET  = 22'h0,
    parameter logic [21:0] PCM_OFFSET  = 22'h0,
    parameter logic [21:0] GFX_OFFSET  = 22'h0,
    parameter int          CLEAR_WORDS = 131072
) (
    input  wire                                  clk,
    input  wire                                  rst_n,
    input  wire  [rom_load_pkg::DL_ADDR_W-1:0]   ioctl_addr,
    input  wire  [7:0]                           ioctl_data,
    input  wire                                  ioctl_wr,
    input  wire                                  downloading,
    input  wire                                  prog_rdy,
    output rom_load_pkg::prog_req_t              prog,
    output wire                                  prog_we,
    output wire                                  prom_we,
    output wire  [12:0]                          prom_addr,
    output wire                                  cfg_we,
    output wire                                  dwnld_busy
);

    import rom_load_pkg::*;

    start_table_t starts;
    route_t       route;
    wire          decrypt;
    wire          scramble_bit;

    rom_header_regs #(
        .REGSIZE  (REGSIZE),
        .CFG_BYTE (CFG_BYTE)
    ) u_header (
        .clk          (clk),
        .rst_n        (rst_n),
        .ioctl_addr   (ioctl_addr),
        .ioctl_data   (ioctl_data),
        .ioctl_wr     (ioctl_wr),
        .downloading  (downloading),
        .starts       (starts),
        .decrypt      (decrypt),
        .scramble_bit (scramble_bit)
    );

    rom_addr_router #(
        .REGSIZE    (REGSIZE),
        .CFG_BYTE   (CFG_BYTE),
        .CPU_OFFSET (CPU_OFFSET),
        .SND_OFFSET (SND_OFFSET),
        .PCM_OFFSET (PCM_OFFSET),
        .GFX_OFFSET (GFX_OFFSET)
    ) u_router (
        .ioctl_addr   (ioctl_addr),
        .ioctl_data   (ioctl_data),
        .starts       (starts),
        .decrypt      (decrypt),
        .scramble_bit (scramble_bit),
        .route        (route)
    );

    rom_prog_writer #(
        .CLEAR_WORDS (CLEAR_WORDS)
    ) u_writer (
        .clk         (clk),
        .rst_n       (rst_n),
        .downloading (downloading),
        .ioctl_wr    (ioctl_wr),
        .route       (route),
        .prog_rdy    (prog_rdy),
        .prog        (prog),
        .prog_we     (prog_we),
        .prom_we     (prom_we),
        .prom_addr   (prom_addr),
        .cfg_we      (cfg_we),
        .dwnld_busy  (dwnld_busy)
    );

endmodule

`default_nettype wire

// ==== hw/rom_prog_writer.sv ====
/*
 * ROM programming writer
 * Registers routed bytes into SDRAM writes held until prog_rdy, pulses
 * the config and internal-ROM strobes, and zeroes work RAM once the
 * download has ended.
 */
`default_nettype none

module rom_prog_writer #(
    parameter int CLEAR_WORDS = 131072
) (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      downloading,
    input  wire                      ioctl_wr,
    input  rom_load_pkg::route_t     route,
    input  wire                      prog_rdy,
    output rom_load_pkg::prog_req_t  prog,
    output logic                     prog_we,
    output logic                     prom_we,
    output logic [12:0]              prom_addr,
    output logic                     cfg_we,
    output logic                     dwnld_busy
);

    import rom_load_pkg::*;

    localparam int CNT_W = $clog2(CLEAR_WORDS + 1);

    wr_state_e  state;
    logic [CNT_W-1:0] clr_cnt;
    logic [CNT_W-1:0] clr_cnt_nxt;
    logic       byte_wr;
    logic       is_prog;
    logic       start_clr;
    logic       clr_ack;
    logic       clr_last;

    assign byte_wr     = ioctl_wr && downloading && state != WR_CLEAR;
    assign is_prog     = route.region inside {RGN_CPU, RGN_SND, RGN_PCM, RGN_GFX};
    assign start_clr   = state == WR_LOAD && !downloading && !prog_we;
    assign clr_ack     = state == WR_CLEAR && prog_we && prog_rdy;
    assign clr_cnt_nxt = clr_cnt + 1'b1;
    assign clr_last    = clr_cnt == CNT_W'(CLEAR_WORDS - 1);
    assign prom_addr   = prog.addr[12:0];   // bulk address mod 8192

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= WR_IDLE;
            prog_we    <= 1'b0;
            prom_we    <= 1'b0;
            cfg_we     <= 1'b0;
            dwnld_busy <= 1'b0;
            clr_cnt    <= '0;
        end else begin
            prom_we <= 1'b0;                    // single-cycle strobes
            cfg_we  <= 1'b0;
            if (byte_wr) begin
                prog_we    <= is_prog;
                prom_we    <= route.region == RGN_QSND;
                cfg_we     <= route.region == RGN_CFG;
                dwnld_busy <= 1'b1;
                state      <= WR_LOAD;
            end else begin
                case (state)
                    WR_LOAD: begin
                        if (prog_we && prog_rdy) begin
                            prog_we <= 1'b0;
                        end else if (start_clr) begin
                            prog_we <= 1'b1;    // first clear word
                            clr_cnt <= '0;
                            state   <= WR_CLEAR;
                        end
                    end
                    WR_CLEAR: begin
                        if (clr_ack) begin
                            prog_we <= 1'b0;
                            clr_cnt <= clr_cnt_nxt;
                            if (clr_last) begin
                                dwnld_busy <= 1'b0;
                                state      <= WR_IDLE;
                            end
                        end else if (!prog_we) begin
                            prog_we <= 1'b1;
                        end
                    end
                    WR_IDLE: ;
                    default: state <= WR_IDLE;
                endcase
            end
        end
    end

    // request payload, no reset needed
    always_ff @(posedge clk) begin
        if (byte_wr) begin
            prog <= route.req;
        end else if (start_clr) begin
            prog <= '0;                         // zero data, mask 00, bank 0
        end else if (clr_ack) begin
            prog.addr <= 22'(clr_cnt_nxt);
        end
    end

endmodule

`default_nettype wire

// ==== rom_loader_top.f ====
hw/rom_load_pkg.sv
hw/rom_header_regs.sv
hw/rom_addr_router.sv
hw/rom_prog_writer.sv
hw/rom_loader_top.sv
tb/rom_loader_sva.sv
tb/rom_loader_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the loader testbench with Verilator, run it and check the log.
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f rom_loader_top.f \
    --top-module rom_loader_tb -o rom_loader_sim \
  && ./obj_dir/rom_loader_sim | tee sim.log \
  && grep -q "All tests passed" sim.log \
  && echo "simulation PASS" \
  || { echo "simulation FAIL"; exit 1; }

// ==== tb/rom_loader_cases.txt ====
# B name addr data kind exp_addr exp_data exp_mask exp_bank (hex, kind 0 none 1 cfg 2 prog 3 prom)
# E ends the download, then the clear sweep is checked
B snd_lo 0 00 0 0 0 0 0
B snd_hi 1 04 0 0 0 0 0
B pcm_lo 2 01 0 0 0 0 0
B pcm_hi 3 04 0 0 0 0 0
B gfx_lo 4 02 0 0 0 0 0
B gfx_hi 5 04 0 0 0 0 0
B qsnd_lo 6 03 0 0 0 0 0
B qsnd_hi 7 04 0 0 0 0 0
B cfg_first 8 12 1 0 0 0 0
B cfg_flags 27 c0 1 0 0 0 0
B hdr_pad 28 ff 0 0 0 0 0
B hdr_last 3f ff 0 0 0 0 0
B cpu_even 40 5a 2 0 5a5a 2 3
B cpu_odd 41 3c 2 0 3c3c 1 3
B cpu_scr_00 80040 00 2 40000 d8d8 2 3
B cpu_plain_odd 80041 00 2 40000 0000 1 3
B cpu_scr_ff 80042 ff 2 40001 6a6a 2 3
B cpu_scr_12 80044 12 2 40002 b9b9 2 3
B cpu_last 10003f 11 2 7ffff 1111 1 3
B snd_first 100040 77 2 10000 7777 2 1
B snd_odd 100043 88 2 10001 8888 1 1
B snd_last 10043f 44 2 101ff 4444 1 1
B pcm_first 100440 99 2 20000 9999 2 1
B gfx_first 100840 ab 2 40000 abab 2 2
B gfx_odd 100845 cd 2 40002 cdcd 1 2
B qsnd_first 100c40 ee 3 0c00 0 0 0
B qsnd_wrap 102045 01 3 0005 0 0 0
E

// ==== tb/rom_loader_sva.sv ====
/*
 * Writer strobe assertions
 * Bound to the SDRAM writer: a held request stays put until acknowledged,
 * the single-cycle strobes stay single, and nothing fires in reset.
 */
`default_nettype none

module rom_loader_sva (
    input wire                           clk,
    input wire                           rst_n,
    input wire                           prog_rdy,
    input wire rom_load_pkg::prog_req_t  prog,
    input wire                           prog_we,
    input wire                           prom_we,
    input wire                           cfg_we
);

    // held write keeps its payload
    assert property (@(posedge clk) disable iff (!rst_n)
        prog_we && !prog_rdy |=> prog_we && $stable(prog))
        else $error("prog_we dropped or prog changed before prog_rdy");

    assert property (@(posedge clk) disable iff (!rst_n) prom_we |=> !prom_we)
        else $error("prom_we stayed high for two cycles");

    assert property (@(posedge clk) disable iff (!rst_n) cfg_we |=> !cfg_we)
        else $error("cfg_we stayed high for two cycles");

    assert property (@(posedge clk) !rst_n |-> !prog_we && !prom_we && !cfg_we)
        else $error("strobe active while in reset");

endmodule

bind rom_prog_writer rom_loader_sva u_sva (
    .clk      (clk),
    .rst_n    (rst_n),
    .prog_rdy (prog_rdy),
    .prog     (prog),
    .prog_we  (prog_we),
    .prom_we  (prom_we),
    .cfg_we   (cfg_we)
);

`default_nettype wire

// ==== tb/rom_loader_tb.sv ====
/*
 * ROM loader testbench
 * Replays the download cases file through the loader, acknowledges SDRAM
 * writes after random delays and checks every strobe, write and the sweep.
 */
`default_nettype none

module rom_loader_tb;

    import rom_load_pkg::*;

    localparam int TIMEOUT     = 400;     // cycles per wait
    localparam int CLEAR_WORDS = 16;

    logic                 clk         = 1'b0;
    logic                 rst_n       = 1'b0;
    logic [DL_ADDR_W-1:0] ioctl_addr  = '0;
    logic [7:0]           ioctl_data  = '0;
    logic                 ioctl_wr    = 1'b0;
    logic                 downloading = 1'b0;
    logic                 prog_rdy    = 1'b0;
    prog_req_t            prog;
    logic                 prog_we;
    logic                 prom_we;
    logic [12:0]          prom_addr;
    logic                 cfg_we;
    logic                 dwnld_busy;

    prog_req_t   wr_q[$];                 // acknowledged writes
    logic [12:0] prom_q[$];
    int          cfg_cnt   = 0;
    int          errors    = 0;
    int          faults    = 0;
    int          wait_left = 0;
    logic        armed     = 1'b0;
    logic        swept     = 1'b0;

    rom_loader_top #(
        .REGSIZE (24), .CFG_BYTE (39),
        .CPU_OFFSET (22'h0), .SND_OFFSET (22'h10000),
        .PCM_OFFSET (22'h20000), .GFX_OFFSET (22'h40000),
        .CLEAR_WORDS (CLEAR_WORDS)
    ) uut (
        .clk (clk), .rst_n (rst_n), .ioctl_addr (ioctl_addr), .ioctl_data (ioctl_data),
        .ioctl_wr (ioctl_wr), .downloading (downloading), .prog_rdy (prog_rdy),
        .prog (prog), .prog_we (prog_we), .prom_we (prom_we), .prom_addr (prom_addr),
        .cfg_we (cfg_we), .dwnld_busy (dwnld_busy)
    );

    always #10 clk = ~clk;

    // SDRAM responder, 1 to 3 cycles per write
    always @(posedge clk) begin
        if (!rst_n) begin
            prog_rdy <= 1'b0;
            armed    <= 1'b0;
        end else begin
            prog_rdy <= 1'b0;
            if (prog_we && !prog_rdy) begin
                if (!armed) begin
                    armed     <= 1'b1;
                    wait_left <= $urandom_range(3, 1);
                end else if (wait_left > 1) begin
                    wait_left <= wait_left - 1;
                end else begin
                    armed    <= 1'b0;
                    prog_rdy <= 1'b1;
                end
            end
        end
    end

    always @(posedge clk) begin           // values from before the edge
        if (prog_we && prog_rdy) wr_q.push_back(prog);
        if (prom_we) prom_q.push_back(prom_addr);
        if (cfg_we) cfg_cnt++;
    end

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("[ERROR] %0s expected %0h actual %0h", name, expected, actual);
        end
    endtask

    task automatic drive_byte(input logic [DL_ADDR_W-1:0] a, input logic [7:0] d);
        @(posedge clk);
        ioctl_addr <= a;
        ioctl_data <= d;
        ioctl_wr   <= 1'b1;
        @(posedge clk);
        ioctl_wr   <= 1'b0;
    endtask

    task automatic wait_writes(input int n, input string what);
        int cycles;
        cycles = 0;
        while (wr_q.size() < n && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (wr_q.size() < n) begin
            faults++;
            $display("timeout: %0s got %0d of %0d SDRAM writes", what, wr_q.size(), n);
        end
    endtask

    task automatic wait_prog_idle(input string what);
        int cycles;
        cycles = 0;
        while (prog_we && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (prog_we) begin
            faults++;
            $display("timeout: prog_we never dropped after %0s", what);
        end
    endtask

    task automatic run_byte(input string name, input logic [DL_ADDR_W-1:0] a,
                            input logic [7:0] d, input int kind, input logic [21:0] ea,
                            input logic [15:0] ed, input logic [1:0] em, input logic [1:0] eb);
        int        cfg_before;
        prog_req_t w;
        cfg_before = cfg_cnt;
        drive_byte(a, d);
        if (kind == 2) begin
            wait_writes(1, name);
            wait_prog_idle(name);
        end else begin
            repeat (3) @(negedge clk);    // strobes land one edge after the byte
        end
        check_value({name, " writes"}, (kind == 2) ? 1 : 0, wr_q.size());
        if (kind == 2 && wr_q.size() > 0) begin
            w = wr_q[0];
            check_value({name, " addr"}, ea, w.addr);
            check_value({name, " data"}, ed, w.data);
            check_value({name, " mask"}, em, w.mask);
            check_value({name, " bank"}, eb, w.bank);
        end
        check_value({name, " prog_we"}, 0, prog_we);
        check_value({name, " cfg_we"}, (kind == 1) ? 1 : 0, cfg_cnt - cfg_before);
        check_value({name, " prom_we"}, (kind == 3) ? 1 : 0, prom_q.size());
        if (kind == 3 && prom_q.size() > 0) check_value({name, " prom_addr"}, ea, prom_q[0]);
        check_value({name, " busy"}, 1, dwnld_busy);
        wr_q.delete();
        prom_q.delete();
    endtask

    task automatic end_download();
        int cycles;
        int early;
        int i;
        @(posedge clk);
        downloading <= 1'b0;
        cycles = 0;
        early  = 0;
        while (wr_q.size() < CLEAR_WORDS && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
            if (wr_q.size() < CLEAR_WORDS && !dwnld_busy) early++;   // busy held through sweep
        end
        if (wr_q.size() < CLEAR_WORDS) begin
            faults++;
            $display("timeout: clear sweep got %0d of %0d SDRAM writes",
                     wr_q.size(), CLEAR_WORDS);
        end
        check_value("busy during sweep", 0, early);
        check_value("busy after sweep", 0, dwnld_busy);   // falls with the last ack
        repeat (3) @(negedge clk);        // no write may follow the sweep
        check_value("clear writes", CLEAR_WORDS, wr_q.size());
        for (i = 0; i < wr_q.size(); i++) begin
            check_value($sformatf("clear %0d addr", i), i, wr_q[i].addr);
            check_value($sformatf("clear %0d payload", i), 0,
                        {wr_q[i].data, wr_q[i].mask, wr_q[i].bank});
        end
        wr_q.delete();
        swept = 1'b1;
    endtask

    initial begin
        int           fd;
        int           n;
        string        line;
        logic [127:0] name_v;
        logic [31:0]  a, d, kind, ea, ed, em, eb;
        void'($urandom(62149));
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        downloading <= 1'b1;
        fd = $fopen("tb/rom_loader_cases.txt", "r");
        if (fd == 0) begin
            faults++;
            $display("could not open the cases file tb/rom_loader_cases.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() < 2 || line[0] == "#") continue;
                if (line[0] == "E") begin
                    end_download();
                end else begin
                    n = $sscanf(line, "B %s %h %h %h %h %h %h %h",
                                name_v, a, d, kind, ea, ed, em, eb);
                    if (n != 8) begin
                        faults++;
                        $display("malformed line in the cases file: %0s", line);
                    end else begin
                        run_byte($sformatf("%0s", name_v), a[DL_ADDR_W-1:0], d[7:0],
                                 int'(kind), ea[21:0], ed[15:0], em[1:0], eb[1:0]);
                    end
                end
            end
            $fclose(fd);
        end
        if (!swept) begin
            faults++;
            $display("the cases file never ended the download");
        end
        $display("mismatches: %0d, timeouts and other failures: %0d", errors, faults);
        if (errors == 0 && faults == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
